//--- src.f
+incdir+source
source/hsci_link_pkg.sv
source/hsci_link_fsm.sv
source/hsci_clk_sweep.sv
source/hsci_pn_lock.sv
source/hsci_linkup_enc.sv
source/hsci_mlink_ctrl.sv
dv/hsci_mlink_tb.sv

//--- Makefile
# Verilator build and run for the hsci link-up controller

VERILATOR ?= verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = hsci_mlink_tb
FILELIST  = src.f
MDIR      = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(MDIR)

run: compile
	-./$(MDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "RESULT: PASS" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(MDIR) $(LOG)

//--- dv/hsci_mlink_tb.sv
/*
 * hsci master link-up testbench
 * slave model with pass mask, frame monitor, reference models and watchdog
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_mlink_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import hsci_link_pkg::*;

   localparam int CLK_PERIOD   = 20;
   localparam int DRIVE_DELAY  = 2;
   localparam int N_LINK_TESTS = 3;
   localparam int SWEEP_CYCLES = `HSCI_TABLE_N * (`HSCI_ACQ_CYCLES + 4);
   localparam int STEP_CYCLES  = `HSCI_TABLE_N * `HSCI_FRAME_LEN * 4 + `HSCI_SETTLE_CYCLES;
   localparam int LINK_CYCLES  = SWEEP_CYCLES + 8 + STEP_CYCLES + `HSCI_IDLE_CYCLES + 200;
   localparam int ERR_CYCLES   = 2 * SWEEP_CYCLES + 200;
   localparam int RX_CYCLES    = `HSCI_RX_LINK_CYCLES + 200;
   localparam int WATCHDOG_CYCLES = N_LINK_TESTS * (LINK_CYCLES + 40) + ERR_CYCLES
                                    + RX_CYCLES + 1000;

   logic                           hsci_pclk = 1'b0;
   logic                           rstn;
   logic                           auto_linkup;
   logic                           menc_pause;
   hsci_mdec_t                     mdec;
   logic [`HSCI_WORD_W-1:0]        linkup_word;
   logic                           link_active;
   hsci_link_err_t                 link_err_info;
   hsci_link_status_t              status;

   logic [31:0] rng_state = 32'hea1de966;
   logic [15:0] pass_mask;      // adjustments where the slave returns data
   logic        det_en;
   logic [14:0] slave_pn = 15'h2AD5;
   int          error_count = 0;
   int          frames_seen = 0;

   hsci_mlink_ctrl u_hsci_mlink_ctrl (
      .hsci_pclk, .rstn, .auto_linkup, .menc_pause, .mdec,
      .linkup_word, .link_active, .link_err_info, .status
   );

   always
   begin
      #(CLK_PERIOD / 2) hsci_pclk = ~hsci_pclk;
   end

   // ******************************************************************
   // reference models
   // ******************************************************************
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // PN15 byte step, new byte in the low bits
   function automatic logic [14:0] pn_next(input logic [14:0] s);
      logic [7:0] b;
      for (int i = 0; i < 8; i++)
         b[i] = s[i + 7] ^ s[i + 6];
      return {s[6:0], b};
   endfunction

   function automatic logic word_parity(input logic [6:0] bits);
      int ones;
      ones = 0;
      for (int i = 0; i < 7; i++)
         ones += bits[i];
      return (ones % 2) == 1;
   endfunction

   function automatic bit window_ok(input logic [15:0] m, input int c, input int half);
      bit ok;
      ok = 1'b1;
      for (int i = c - half; i <= c + half; i++)
         if (!m[(i + `HSCI_TABLE_N) % `HSCI_TABLE_N])
            ok = 1'b0;
      return ok;
   endfunction

   // centred setting for a pass mask, -1 when nothing fits
   function automatic int decide(input logic [15:0] m);
      for (int c = 1; c <= 13; c += 3)
         if (window_ok(m, c, 3))
            return c;
      for (int c = 0; c < `HSCI_TABLE_N; c += 2)
         if (window_ok(m, c, 2))
            return c;
      for (int c = 0; c < `HSCI_TABLE_N; c++)
         if (window_ok(m, c, 1))
            return c;
      return -1;
   endfunction

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected)
      begin
         error_count++;
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
         $display("RESULT: FAIL");
         $fatal(1, "value mismatch");
      end
   endtask

   // ******************************************************************
   // slave model and pause stimulus
   // ******************************************************************
   initial
   begin
      menc_pause = 1'b0;
      mdec       = '0;
      forever
      begin
         @(posedge hsci_pclk);
         #(DRIVE_DELAY);
         rng_state  = xorshift32(rng_state);
         menc_pause = (rng_state[1:0] == 2'b00);
         mdec.signal_det = det_en;
         if (det_en && pass_mask[status.alink_txclk_adj])
         begin
            slave_pn         = pn_next(slave_pn);
            mdec.alink_dval  = 1'b1;
            mdec.alink_data  = slave_pn[7:0];
         end
         else
         begin
            mdec.alink_dval  = 1'b0;
            mdec.alink_data  = '0;
         end
         mdec.idle_state = (linkup_word == '0);   // decoder sees no words
      end
   end

   // ******************************************************************
   // frame monitor
   // ******************************************************************
   logic [2:0]              ref_pos;
   logic [14:0]             ref_pn;
   logic                    exp_new;
   logic                    exp_zero;
   logic                    exp_hold;
   logic                    words_on;
   logic [`HSCI_WORD_W-1:0] held_word;

   task automatic check_frame_word(input logic [`HSCI_WORD_W-1:0] w);
      logic [`HSCI_WORD_W-1:0] expected;
      if (ref_pos == 3'd0)
      begin
         check_value("linkup_word[9:5]", w[9:5], {1'b1, `HSCI_LINKUP_INSTR});
         check_value("linkup_word[4:2] <= 3", w[4:2] <= 3'd3, 1);
         check_value("linkup_word[1]", w[1], word_parity(w[9:3]));
         check_value("linkup_word[0]", w[0], 1'b0);
      end
      else if (ref_pos == 3'(`HSCI_FRAME_LEN - 1))
      begin
         check_value("linkup_word", w, 0);   // idle word
         frames_seen++;
      end
      else
      begin
         ref_pn   = pn_next(ref_pn);
         expected = {ref_pn[7:0], word_parity(ref_pn[7:1]), ref_pos != 3'd6};
         check_value("linkup_word", w, expected);
      end
      ref_pos = ref_pos + 3'd1;
   endtask

   always @(negedge hsci_pclk)
   begin
      if (!rstn)
      begin
         ref_pos  = '0;
         ref_pn   = 15'h7FFF;
         exp_new  = 1'b0;
         exp_zero = 1'b0;
         exp_hold = 1'b0;
      end
      else
      begin
         if (exp_new)
            check_frame_word(linkup_word);
         else if (exp_zero)
            check_value("linkup_word", linkup_word, 0);
         else if (exp_hold)
            check_value("linkup_word", linkup_word, held_word);
         // what the coming edge does to the word
         words_on  = auto_linkup && (status.alink_fsm != TX_LINKUP)
                     && (status.alink_fsm != LINKUP);
         exp_new   = words_on && !menc_pause;
         exp_hold  = words_on && menc_pause;
         exp_zero  = !words_on;
         held_word = linkup_word;
         if (!words_on)
            ref_pos = '0;
      end
   end

   // ******************************************************************
   // sequencing tasks
   // ******************************************************************
   task automatic apply_reset(input logic [15:0] m, input logic det);
      @(negedge hsci_pclk);
      pass_mask = m;
      det_en    = det;
      @(posedge hsci_pclk);
      #(DRIVE_DELAY);
      rstn        = 1'b0;
      auto_linkup = 1'b0;
      repeat (16) @(posedge hsci_pclk);
      #(DRIVE_DELAY);
      rstn = 1'b1;
   endtask

   task automatic start_link();
      @(posedge hsci_pclk);
      #(DRIVE_DELAY);
      auto_linkup = 1'b1;
   endtask

   task automatic wait_for_state(input logic [3:0] s, input int max_cycles,
                                 input string what, output int cycles);
      cycles = 0;
      @(negedge hsci_pclk);
      while (status.alink_fsm !== s)
      begin
         if (cycles >= max_cycles)
         begin
            $display("timeout: state %s not reached within %0d cycles", what, max_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "state wait timed out");
         end
         cycles++;
         @(negedge hsci_pclk);
      end
   endtask

   task automatic run_link_test(input logic [15:0] m);
      int exp_target;
      int n;
      exp_target = decide(m);
      apply_reset(m, 1'b1);
      start_link();
      wait_for_state(TX_LINKUP, LINK_CYCLES, "TX_LINKUP", n);
      wait_for_state(LINKUP, 4 * `HSCI_IDLE_CYCLES, "LINKUP", n);
      // n leaves out the first TX_LINKUP cycle
      check_value("TX_LINKUP cycles >= HSCI_IDLE_CYCLES", n + 1 >= `HSCI_IDLE_CYCLES, 1);
      @(negedge hsci_pclk);
      check_value("link_active", link_active, 1'b1);
      check_value("status.alink_fsm", status.alink_fsm, LINKUP);
      check_value("status.alink_table", status.alink_table, m);
      check_value("status.alink_txclk_adj", status.alink_txclk_adj, exp_target);
      check_value("status.alink_txclk_inv", status.alink_txclk_inv, 1'b0);
      check_value("link_err_info", link_err_info, 0);
   endtask

   task automatic run_no_window_test(input logic [15:0] m);
      int n;
      apply_reset(m, 1'b1);
      start_link();
      wait_for_state(TX_CLK_INV, SWEEP_CYCLES + 100, "TX_CLK_INV", n);
      check_value("status.alink_table", status.alink_table, m);
      @(negedge hsci_pclk);
      check_value("status.alink_txclk_inv", status.alink_txclk_inv, 1'b1);
      wait_for_state(LINK_ERR, ERR_CYCLES, "LINK_ERR", n);
      repeat (2) @(negedge hsci_pclk);
      check_value("status.alink_table", status.alink_table, m);
      check_value("link_err_info.dec_made", link_err_info.dec_made, 1'b0);
      check_value("link_err_info.rx_link_to", link_err_info.rx_link_to, 1'b0);
      check_value("link_err_info.prev_state", link_err_info.prev_state, TX_DECIDE);
      check_value("link_active", link_active, 1'b0);
   endtask

   task automatic run_rx_timeout_test();
      int n;
      apply_reset(16'hFFFF, 1'b0);   // slave never answers
      start_link();
      wait_for_state(LINK_ERR, RX_CYCLES, "LINK_ERR", n);
      repeat (2) @(negedge hsci_pclk);
      check_value("link_err_info.rx_link_to", link_err_info.rx_link_to, 1'b1);
      check_value("link_err_info.prev_state", link_err_info.prev_state, RX_LINK);
      check_value("link_active", link_active, 1'b0);
   endtask

   // ******************************************************************
   // main sequence
   // ******************************************************************
   initial
   begin
      logic [15:0] m;
      rstn        = 1'b0;
      auto_linkup = 1'b0;
      pass_mask   = '0;
      det_en      = 1'b0;
      apply_reset(16'hFFFF, 1'b1);
      repeat (2) @(negedge hsci_pclk);
      check_value("linkup_word", linkup_word, 0);
      check_value("link_active", link_active, 1'b0);
      check_value("link_err_info", link_err_info, 0);
      check_value("status.alink_fsm", status.alink_fsm, IDLE);
      check_value("status.alink_table", status.alink_table, 0);

      for (int t = 0; t < N_LINK_TESTS; t++)
      begin
         do
         begin
            rng_state = xorshift32(rng_state);
            m = (t == 0) ? (rng_state[15:0] | rng_state[31:16]) : rng_state[15:0];
         end
         while (decide(m) < 0);
         run_link_test(m);
      end

      do
      begin
         rng_state = xorshift32(rng_state);
         m = rng_state[15:0] & rng_state[31:16];   // sparse, no window
      end
      while (decide(m) >= 0);
      run_no_window_test(m);

      run_rx_timeout_test();
      check_value("frames_seen > 0", frames_seen > 0, 1);

      if (error_count == 0)
      begin
         $display("RESULT: PASS");
         $finish;
      end
      else
      begin
         $display("RESULT: FAIL");
         $fatal(1, "checks failed");
      end
   end

   initial
   begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
      $display("RESULT: FAIL");
      $fatal(1, "watchdog expired");
   end

endmodule

`default_nettype wire

//--- source/hsci_mlink_ctrl.sv
/*
 * hsci master auto link-up controller
 * ties FSM, clock sweep, lock detector and encoder, packs status
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_mlink_ctrl (
   input  logic                             hsci_pclk,
   input  logic                             rstn,
   input  logic                             auto_linkup,
   input  logic                             menc_pause,
   input  hsci_link_pkg::hsci_mdec_t        mdec,
   output logic [`HSCI_WORD_W-1:0]          linkup_word,
   output logic                             link_active,
   output hsci_link_pkg::hsci_link_err_t    link_err_info,
   output hsci_link_pkg::hsci_link_status_t status
);
   import hsci_link_pkg::*;

   hsci_link_state_e         state;
   hsci_link_state_e         prev_state;
   logic                     acq_active;
   logic                     rx_link_to;
   logic                     acq_to;
   logic                     linkup_achieved;
   logic                     signal_lock;
   logic                     sweep_last;
   logic                     dec_made;
   logic                     dec_none;
   logic                     tx_clk_inv;
   logic                     at_target;
   logic                     frame_end;
   logic [`HSCI_ADJ_W-1:0]   tx_clk_adj;
   logic [`HSCI_ADJ_W-1:0]   target;
   logic [`HSCI_TABLE_N-1:0] pass_table;
   logic                     err_captured;

   hsci_link_fsm u_fsm (
      .hsci_pclk, .rstn, .auto_linkup, .mdec, .signal_lock, .sweep_last,
      .dec_made, .dec_none, .tx_clk_inv, .at_target, .state, .prev_state,
      .acq_active, .rx_link_to, .acq_to, .linkup_achieved, .link_active
   );

   hsci_clk_sweep u_sweep (
      .hsci_pclk, .rstn, .state, .prev_state, .signal_lock, .frame_end,
      .tx_clk_adj, .target, .tx_clk_inv, .sweep_last, .dec_made, .dec_none,
      .at_target, .pass_table
   );

   hsci_pn_lock u_pn_lock (
      .hsci_pclk, .rstn, .acq_active,
      .clear (state == TX_ENDLP),   // result is taken, restart
      .mdec, .signal_lock
   );

   hsci_linkup_enc u_enc (
      .hsci_pclk, .rstn, .auto_linkup, .menc_pause, .state, .tx_clk_adj,
      .linkup_word, .frame_end
   );

   assign status = '{alink_fsm:       state,
                     alink_table:     pass_table,
                     alink_txclk_adj: tx_clk_adj,
                     alink_txclk_inv: tx_clk_inv};

   // diagnostic word, taken once on entry to error
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         link_err_info <= '0;
         err_captured  <= 1'b0;
      end
      else if ((state == LINK_ERR) && !err_captured)
      begin
         link_err_info <= '{zero:            '0,
                            linkup_achieved: linkup_achieved,
                            tx_clk_adj:      tx_clk_adj,
                            target:          target,
                            dec_made:        dec_made,
                            acq_to:          acq_to,
                            rx_link_to:      rx_link_to,
                            signal_lock:     signal_lock,
                            prev_state:      prev_state};
         err_captured  <= 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- source/hsci_linkup_enc.sv
/*
 * link-up word encoder
 * frames of command, PN15 data and idle words with parity
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_linkup_enc (
   input  logic                            hsci_pclk,
   input  logic                            rstn,
   input  logic                            auto_linkup,
   input  logic                            menc_pause,
   input  hsci_link_pkg::hsci_link_state_e state,
   input  logic [`HSCI_ADJ_W-1:0]          tx_clk_adj,
   output logic [`HSCI_WORD_W-1:0]         linkup_word,
   output logic                            frame_end
);
   import hsci_link_pkg::*;

   logic [2:0]             pos;          // frame position
   logic [14:0]            pn_sreg;
   logic [`HSCI_ADJ_W-1:0] adj_d;
   hsci_tx_ctrl_e          tx_ctrl;
   logic                   words_on;
   logic                   advance;
   logic [7:0]             payload;
   logic                   flag;
   logic [`HSCI_WORD_W-1:0] next_word;

   assign words_on  = auto_linkup && (state != TX_LINKUP) && (state != LINKUP);
   assign advance   = words_on && !menc_pause;
   assign frame_end = advance && (pos == 3'(`HSCI_FRAME_LEN - 1));

   // word being formed at this position
   always_comb
   begin
      if (pos == 3'd0)
      begin
         payload = {1'b1, `HSCI_LINKUP_INSTR, tx_ctrl};
         flag    = 1'b0;
      end
      else
      begin
         payload = pn15_byte(pn_sreg);
         flag    = (pos != 3'd6);   // last data word has bit0 clear
      end
      next_word = {payload, ^payload[7:1], flag};
      if (pos == 3'(`HSCI_FRAME_LEN - 1))
         next_word = '0;   // idle
   end

   // ******************************************************************
   // control code
   // ******************************************************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_ctrl <= CTRL_NONE;
         adj_d   <= '1;
      end
      else if (!words_on)
      begin
         tx_ctrl <= CTRL_NONE;
         adj_d   <= tx_clk_adj;
      end
      else
      begin
         adj_d <= (state == TX_CLK_INV) ? '1 : tx_clk_adj;
         if (state == TX_CLK_INV)
            tx_ctrl <= CTRL_INV;
         else if (tx_clk_adj < adj_d)
            tx_ctrl <= CTRL_DEC;
         else if (tx_clk_adj > adj_d)
            tx_ctrl <= CTRL_INC;
         else if (advance && (pos == 3'd0))
            tx_ctrl <= CTRL_NONE;   // sent once per frame
      end
   end

   // ******************************************************************
   // frame counter, generator and output word
   // ******************************************************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         linkup_word <= '0;
         pos         <= '0;
         pn_sreg     <= 15'h7FFF;
      end
      else if (!words_on)
      begin
         linkup_word <= '0;
         pos         <= '0;
      end
      else if (advance)
      begin
         linkup_word <= next_word;
         pos         <= pos + 3'd1;
         if ((pos != 3'd0) && (pos != 3'(`HSCI_FRAME_LEN - 1)))
            pn_sreg <= pn15_step(pn_sreg);
      end
   end

endmodule

`default_nettype wire

//--- source/hsci_pn_lock.sv
/*
 * PN15 lock detector
 * predicts returned bytes and flags lock after a run of matches
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_pn_lock (
   input  logic                      hsci_pclk,
   input  logic                      rstn,
   input  logic                      acq_active,
   input  logic                      clear,
   input  hsci_link_pkg::hsci_mdec_t mdec,
   output logic                      signal_lock
);
   import hsci_link_pkg::*;

   logic [14:0] lock_sreg;
   logic [7:0]  match_cnt;
   logic [7:0]  predicted;

   assign predicted = pn15_byte(lock_sreg);

   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         lock_sreg   <= 15'h7FFF;
         match_cnt   <= '0;
         signal_lock <= 1'b0;
      end
      else if (clear)
      begin
         match_cnt   <= '0;
         signal_lock <= 1'b0;
      end
      else if (acq_active && mdec.alink_dval)
      begin
         if (lock_sreg == '0)
            lock_sreg <= 15'h7FFF;   // escape the stuck state
         else if (mdec.alink_data != predicted)
         begin
            lock_sreg <= {lock_sreg[6:0], mdec.alink_data};   // reseed
            match_cnt <= '0;
         end
         else
         begin
            lock_sreg <= pn15_step(lock_sreg);
            if (match_cnt == 8'(`HSCI_LOCK_MATCHES - 1))
               signal_lock <= 1'b1;
            else
               match_cnt <= match_cnt + 8'd1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/hsci_clk_sweep.sv
/*
 * slave tx clock sweep
 * adjustment and inversion registers, pass table and centred window pick
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_clk_sweep (
   input  logic                            hsci_pclk,
   input  logic                            rstn,
   input  hsci_link_pkg::hsci_link_state_e state,
   input  hsci_link_pkg::hsci_link_state_e prev_state,
   input  logic                            signal_lock,
   input  logic                            frame_end,
   output logic [`HSCI_ADJ_W-1:0]          tx_clk_adj,
   output logic [`HSCI_ADJ_W-1:0]          target,
   output logic                            tx_clk_inv,
   output logic                            sweep_last,
   output logic                            dec_made,
   output logic                            dec_none,
   output logic                            at_target,
   output logic [`HSCI_TABLE_N-1:0]        pass_table
);
   import hsci_link_pkg::*;

   logic [1:0]               dec_cnt;   // sum, 7, 5, 3
   logic                     found;
   logic [4:0]               win7;
   logic [7:0]               win5;
   logic [`HSCI_TABLE_N-1:0] win3;
   logic [`HSCI_ADJ_W-1:0]   pick7;
   logic [`HSCI_ADJ_W-1:0]   pick5;
   logic [`HSCI_ADJ_W-1:0]   pick3;
   logic                     dec_last;

   // all entries of a circular window around c pass
   function automatic logic win_pass(input logic [`HSCI_TABLE_N-1:0] t,
                                     input int c, input int half);
      logic ok;
      ok = 1'b1;
      for (int i = -half; i <= half; i++)
      begin
         ok = ok & t[(c + i + `HSCI_TABLE_N) % `HSCI_TABLE_N];
      end
      return ok;
   endfunction

   // lowest passing centre wins
   always_comb
   begin
      pick7 = '0;
      pick5 = '0;
      pick3 = '0;
      for (int k = 4; k >= 0; k--)
         if (win7[k]) pick7 = `HSCI_ADJ_W'(3 * k + 1);
      for (int k = 7; k >= 0; k--)
         if (win5[k]) pick5 = `HSCI_ADJ_W'(2 * k);
      for (int k = `HSCI_TABLE_N - 1; k >= 0; k--)
         if (win3[k]) pick3 = `HSCI_ADJ_W'(k);
   end

   assign dec_last   = (state == TX_DECIDE) && (dec_cnt == 2'd3);
   assign dec_made   = dec_last && (found || (|win3));
   assign dec_none   = dec_last && !found && !(|win3);
   assign sweep_last = (tx_clk_adj == '0);
   assign at_target  = (tx_clk_adj == target);

   // ******************************************************************
   // sweep and decision registers
   // ******************************************************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_clk_adj <= '1;
         target     <= '0;
         tx_clk_inv <= 1'b0;
         pass_table <= '0;
         dec_cnt    <= '0;
         found      <= 1'b0;
         win7       <= '0;
         win5       <= '0;
         win3       <= '0;
      end
      else
      begin
         case (state)
            IDLE:
            begin
               tx_clk_adj <= '1;
               tx_clk_inv <= 1'b0;
               pass_table <= '0;
               found      <= 1'b0;
            end
            TX_CLK_ADJ:
            begin
               if ((prev_state == TX_DETECT) || (prev_state == TX_CLK_INV))
               begin
                  tx_clk_adj <= '1;   // sweep starts at the top
                  pass_table <= '0;
               end
               else
                  tx_clk_adj <= tx_clk_adj - 1'b1;
               dec_cnt <= '0;
               found   <= 1'b0;
            end
            TX_ENDLP:
               pass_table[tx_clk_adj] <= signal_lock;
            TX_DECIDE:
            begin
               dec_cnt <= dec_cnt + 2'd1;
               case (dec_cnt)
                  2'd0:
                  begin
                     for (int k = 0; k < 5; k++)
                        win7[k] <= win_pass(pass_table, 3 * k + 1, 3);
                     for (int k = 0; k < 8; k++)
                        win5[k] <= win_pass(pass_table, 2 * k, 2);
                     for (int k = 0; k < `HSCI_TABLE_N; k++)
                        win3[k] <= win_pass(pass_table, k, 1);
                  end
                  2'd1:
                  begin
                     if (|win7)
                     begin
                        target <= pick7;
                        found  <= 1'b1;
                     end
                  end
                  2'd2:
                  begin
                     if (!found && (|win5))
                     begin
                        target <= pick5;
                        found  <= 1'b1;
                     end
                  end
                  default:
                  begin
                     if (!found && (|win3))
                        target <= pick3;
                  end
               endcase
            end
            TX_CLK_INV:
            begin
               tx_clk_inv <= 1'b1;
               tx_clk_adj <= '1;   // inversion resets the slave adjustment
               pass_table <= '0;
            end
            SET_TXCLK:
            begin
               if (frame_end && !at_target)
                  tx_clk_adj <= tx_clk_adj + 1'b1;   // one step per frame
            end
            default:
            begin
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/hsci_link_fsm.sv
/*
 * hsci link-up state machine
 * sequences detect, sweep, decision and idle qualification with timeouts
 */
`default_nettype none
`include "hsci_link_params.svh"

module hsci_link_fsm (
   input  logic                            hsci_pclk,
   input  logic                            rstn,
   input  logic                            auto_linkup,
   input  hsci_link_pkg::hsci_mdec_t       mdec,
   input  logic                            signal_lock,
   input  logic                            sweep_last,
   input  logic                            dec_made,
   input  logic                            dec_none,
   input  logic                            tx_clk_inv,
   input  logic                            at_target,
   output hsci_link_pkg::hsci_link_state_e state,
   output hsci_link_pkg::hsci_link_state_e prev_state,
   output logic                            acq_active,
   output logic                            rx_link_to,
   output logic                            acq_to,
   output logic                            linkup_achieved,
   output logic                            link_active
);
   import hsci_link_pkg::*;

   logic [19:0] rx_cnt;      // signal-detect timeout
   logic [15:0] acq_cnt;     // per-setting acquisition window
   logic [3:0]  settle_cnt;
   logic [6:0]  idle_cnt;

   assign acq_active = (state == TX_ACQ);

   // ******************************************************************
   // state register and counters
   // ******************************************************************
   always_ff @(posedge hsci_pclk or negedge rstn)
   begin
      if (!rstn)
      begin
         state           <= IDLE;
         prev_state      <= IDLE;
         rx_cnt          <= '0;
         acq_cnt         <= '0;
         settle_cnt      <= '0;
         idle_cnt        <= '0;
         rx_link_to      <= 1'b0;
         acq_to          <= 1'b0;
         linkup_achieved <= 1'b0;
         link_active     <= 1'b0;
      end
      else
      begin
         prev_state <= state;
         case (state)
            IDLE:
            begin
               rx_cnt          <= '0;
               acq_cnt         <= '0;
               rx_link_to      <= 1'b0;
               acq_to          <= 1'b0;
               linkup_achieved <= 1'b0;
               link_active     <= 1'b0;
               if (auto_linkup)
                  state <= RX_LINK;
            end
            RX_LINK:
            begin
               rx_cnt <= rx_cnt + 20'd1;
               if (mdec.signal_det)
                  state <= TX_DETECT;
               else if (rx_cnt == `HSCI_RX_LINK_CYCLES)
               begin
                  rx_link_to <= 1'b1;
                  state      <= LINK_ERR;
               end
            end
            TX_DETECT:
            begin
               if (mdec.signal_det)
                  state <= TX_CLK_ADJ;
            end
            TX_CLK_ADJ:
            begin
               acq_cnt <= '0;
               acq_to  <= 1'b0;
               state   <= TX_ACQ;
            end
            TX_ACQ:
            begin
               acq_cnt <= acq_cnt + 16'd1;
               if (signal_lock)
                  state <= TX_ENDLP;
               else if (acq_cnt == `HSCI_ACQ_CYCLES)
               begin
                  acq_to <= 1'b1;   // no lock at this setting
                  state  <= TX_ENDLP;
               end
            end
            TX_ENDLP:
               state <= sweep_last ? TX_DECIDE : TX_CLK_ADJ;
            TX_DECIDE:
            begin
               settle_cnt <= '0;
               if (dec_made)
                  state <= SET_TXCLK;
               else if (dec_none)
                  state <= tx_clk_inv ? LINK_ERR : TX_CLK_INV;
            end
            TX_CLK_INV:
               state <= TX_CLK_ADJ;
            SET_TXCLK:
            begin
               // slave needs time after the last step
               if (!at_target)
                  settle_cnt <= '0;
               else if (settle_cnt == 4'(`HSCI_SETTLE_CYCLES - 1))
                  state <= TX_LINKUP;
               else
                  settle_cnt <= settle_cnt + 4'd1;
               idle_cnt <= '0;
            end
            TX_LINKUP:
            begin
               linkup_achieved <= 1'b1;
               if (!mdec.idle_state)
                  idle_cnt <= '0;
               else if (idle_cnt == 7'(`HSCI_IDLE_CYCLES - 1))
                  state <= LINKUP;
               else
                  idle_cnt <= idle_cnt + 7'd1;
            end
            LINKUP:
               link_active <= 1'b1;
            LINK_ERR:
               state <= LINK_ERR;   // parked until reset
            default:
               state <= LINK_ERR;
         endcase
      end
   end

endmodule

`default_nettype wire

//--- source/hsci_link_pkg.sv
/*
 * hsci link-up types
 * state and control codes, decoder and status structs, PN15 helpers
 */
`default_nettype none
`include "hsci_link_params.svh"

package hsci_link_pkg;

   typedef enum logic [3:0] {
      IDLE       = 4'h0,
      RX_LINK    = 4'h1,
      TX_DETECT  = 4'h2,
      TX_CLK_ADJ = 4'h3,
      TX_ACQ     = 4'h5,
      TX_ENDLP   = 4'h6,
      TX_DECIDE  = 4'h8,
      TX_CLK_INV = 4'h9,
      SET_TXCLK  = 4'hA,
      TX_LINKUP  = 4'hC,
      LINKUP     = 4'hD,
      LINK_ERR   = 4'hE
   } hsci_link_state_e;

   // code carried in the command word
   typedef enum logic [2:0] {
      CTRL_NONE = 3'd0,
      CTRL_INC  = 3'd1,
      CTRL_DEC  = 3'd2,
      CTRL_INV  = 3'd3
   } hsci_tx_ctrl_e;

   typedef struct packed {
      logic       signal_det;
      logic       alink_dval;
      logic [7:0] alink_data;
      logic       idle_state;
   } hsci_mdec_t;

   typedef struct packed {
      logic [3:0]                 alink_fsm;
      logic [`HSCI_TABLE_N-1:0]   alink_table;
      logic [`HSCI_ADJ_W-1:0]     alink_txclk_adj;
      logic                       alink_txclk_inv;
   } hsci_link_status_t;

   typedef struct packed {
      logic [14:0]            zero;
      logic                   linkup_achieved;
      logic [`HSCI_ADJ_W-1:0] tx_clk_adj;
      logic [`HSCI_ADJ_W-1:0] target;
      logic                   dec_made;
      logic                   acq_to;
      logic                   rx_link_to;
      logic                   signal_lock;
      logic [3:0]             prev_state;
   } hsci_link_err_t;

   // next PN15 byte, each bit the xor of two adjacent register bits
   function automatic logic [7:0] pn15_byte(input logic [14:0] sreg);
      logic [7:0] b;
      for (int i = 0; i < 8; i++)
      begin
         b[i] = sreg[i+7] ^ sreg[i+6];
      end
      return b;
   endfunction

   function automatic logic [14:0] pn15_step(input logic [14:0] sreg);
      return {sreg[6:0], pn15_byte(sreg)};
   endfunction

endpackage

`default_nettype wire

//--- source/hsci_link_params.svh
/*
 * hsci link-up controller constants
 * counts, widths and frame fields shared by the link-up blocks
 */
`ifndef HSCI_LINK_PARAMS_SVH
`define HSCI_LINK_PARAMS_SVH

// clock adjustment sweep
`define HSCI_ADJ_W          4
`define HSCI_TABLE_N        16

// link-up word and frame
`define HSCI_WORD_W         10
`define HSCI_LINKUP_INSTR   4'b0101
`define HSCI_FRAME_LEN      8

// timeouts and qualification counts
`define HSCI_RX_LINK_CYCLES 20'hFFFFF
`define HSCI_ACQ_CYCLES     16'h07FF
`define HSCI_LOCK_MATCHES   128
`define HSCI_IDLE_CYCLES    64
`define HSCI_SETTLE_CYCLES  15

`endif
